// ==== verilog/tileMemPkg.sv ====
// Shared widths, address-region decode constants, fabric opcodes
// and the fabric transaction struct

package tileMemPkg;

    // ================================================
    // Basic types
    // ================================================
    typedef logic [31:0] word;      // Data and address word
    typedef logic [3:0]  byteEn;    // One bit per byte lane
    typedef logic [7:0]  tileId;    // Lives in address bits 31:24
    typedef logic [1:0]  fabOp;     // Fabric opcode

    // Opcodes
    localparam fabOp opRead    = 2'd0;
    localparam fabOp opWrite   = 2'd1;
    localparam fabOp opReadRsp = 2'd2;

    // ================================================
    // Address map
    // ================================================
    localparam int tileMsb   = 31;          // Tile field
    localparam int tileLsb   = 24;
    localparam int regionMsb = 23;          // Region field inside the tile
    localparam int regionLsb = 22;

    localparam logic [1:0] iMemRegion = 2'd0;
    localparam logic [1:0] dMemRegion = 2'd1;
    // Codes 2 and 3 decode to nothing

    localparam tileId localAlias = 8'd0;    // Tile 0 is always this tile

    // ================================================
    // Fabric transaction
    // ================================================
    typedef struct packed {
        word   address;
        word   data;
        fabOp  opcode;
        tileId requestorId;
    } tileTrans;

endpackage

// ==== verilog/dualPortRam.sv ====
// Behavioral two-port RAM, byte-enable writes and a registered read
// on each port

`timescale 1ns/100ps

module dualPortRam #(
    parameter int adrsWidth = 10
) (
    input  logic                 Clock,
    // Port A
    input  logic [adrsWidth-1:0] addrA,
    input  tileMemPkg::word      wrDataA,
    input  logic                 wrEnA,
    input  tileMemPkg::byteEn    byteEnA,
    output tileMemPkg::word      rdDataA,
    // Port B
    input  logic [adrsWidth-1:0] addrB,
    input  tileMemPkg::word      wrDataB,
    input  logic                 wrEnB,
    input  tileMemPkg::byteEn    byteEnB,
    output tileMemPkg::word      rdDataB
);
    import tileMemPkg::*;

    word mem [2**adrsWidth];    // No init, undefined until written

    // Both ports in one process, B lands last on a same-address clash
    always_ff @(posedge Clock) begin
        rdDataA <= mem[addrA];  // Read-before-write
        rdDataB <= mem[addrB];
        for (int i = 0; i < $bits(byteEn); i++) begin
            if (wrEnA && byteEnA[i]) begin
                mem[addrA][8*i +: 8] <= wrDataA[8*i +: 8];
            end
            if (wrEnB && byteEnB[i]) begin
                mem[addrB][8*i +: 8] <= wrDataB[8*i +: 8];
            end
        end
    end

endmodule

// ==== verilog/transFifo.sv ====
// Synchronous FIFO of fabric transactions with empty, full and
// almost-full flags

`timescale 1ns/100ps

module transFifo #(
    parameter int depth = 4
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 push,
    input  tileMemPkg::tileTrans pushData,
    input  logic                 pop,
    output tileMemPkg::tileTrans popData,
    output logic                 empty,
    output logic                 full,
    output logic                 almostFull
);
    import tileMemPkg::*;

    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);

    tileTrans              entries [depth];   // Payload, no reset
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [cntWidth-1:0]   count;
    logic                  doPush;
    logic                  doPop;

    assign doPush = push && !full;      // Push while full is dropped
    assign doPop  = pop && !empty;

    // ================================================
    // Pointers and occupancy
    // ================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + cntWidth'(doPush) - cntWidth'(doPop);
        end
    end

    always_ff @(posedge Clock) begin
        if (doPush) entries[wrPtr] <= pushData;
    end

    assign popData    = entries[rdPtr];     // Head seen without a pop
    assign empty      = (count == '0);
    assign full       = (count == cntWidth'(depth));
    assign almostFull = (count >= cntWidth'(depth - 1));   // At most one slot left

endmodule

// ==== verilog/coreRemoteRequester.sv ====
// Local/remote split of core data accesses, remote ones queued
// as fabric requests

`timescale 1ns/100ps

module coreRemoteRequester #(
    parameter int fifoDepth = 4
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  tileMemPkg::tileId    localTileId,
    input  tileMemPkg::word      dMemAddrQ103H,
    input  tileMemPkg::word      dMemWrDataQ103H,
    input  logic                 dMemWrEnQ103H,
    input  logic                 dMemRdEnQ103H,
    output logic                 localWrEnQ103H,
    input  logic                 reqPop,
    output tileMemPkg::tileTrans reqHead,
    output logic                 reqEmpty,
    output logic                 coreStall
);
    import tileMemPkg::*;

    tileId    addrTileQ103H;
    logic     isLocalQ103H;
    logic     remoteValidQ103H;
    tileTrans reqQ103H;

    assign addrTileQ103H  = dMemAddrQ103H[tileMsb:tileLsb];
    assign isLocalQ103H   = (addrTileQ103H == localTileId) || (addrTileQ103H == localAlias);
    assign localWrEnQ103H = dMemWrEnQ103H && isLocalQ103H;    // To port A of data RAM
    assign remoteValidQ103H = (dMemWrEnQ103H || dMemRdEnQ103H) && !isLocalQ103H;

    // Request as it goes on the fabric
    assign reqQ103H.address     = dMemAddrQ103H;
    assign reqQ103H.data        = dMemWrDataQ103H;
    assign reqQ103H.opcode      = dMemWrEnQ103H ? opWrite : opRead;
    assign reqQ103H.requestorId = localTileId;

    transFifo #(.depth(fifoDepth)) reqFifo (
        .Clock      (Clock),
        .reset      (reset),
        .push       (remoteValidQ103H),
        .pushData   (reqQ103H),
        .pop        (reqPop),           // Granted by the arbiter
        .popData    (reqHead),
        .empty      (reqEmpty),
        .full       (coreStall),        // Core holds off remote accesses
        .almostFull ()
    );

endmodule

// ==== verilog/fabricSlave.sv ====
// Fabric request decode onto the RAMs' port B, read-response build
// and response queue

`timescale 1ns/100ps

module fabricSlave #(
    parameter int iMemAdrsWidth = 10,
    parameter int dMemAdrsWidth = 10,
    parameter int fifoDepth     = 4
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  tileMemPkg::tileId    localTileId,
    input  logic                 inFabricValidQ503H,
    input  tileMemPkg::tileTrans inFabric,
    output logic                 iMemWrEnB,
    output logic                 dMemWrEnB,
    input  tileMemPkg::word      iMemRdDataB,
    input  tileMemPkg::word      dMemRdDataB,
    input  logic                 rspPop,
    output tileMemPkg::tileTrans rspHead,
    output logic                 rspEmpty,
    output logic                 inFabricStall
);
    import tileMemPkg::*;

    logic [1:0]           regionQ503H;
    logic [regionLsb-3:0] wordOffQ503H;     // Word offset inside a region
    logic                 iMemHitQ503H;
    logic                 dMemHitQ503H;
    logic                 rdValidQ503H;
    logic                 iMemHitQ504H;
    logic                 dMemHitQ504H;
    logic                 rdValidQ504H;
    word                  rspAddrQ504H;
    tileTrans             rspQ504H;

    // ================================================
    // Q503H decode
    // ================================================
    assign regionQ503H  = inFabric.address[regionMsb:regionLsb];
    assign wordOffQ503H = inFabric.address[regionLsb-1:2];

    // Hit only inside the RAM's real size, no aliasing above it
    assign iMemHitQ503H = (regionQ503H == iMemRegion) && ((wordOffQ503H >> iMemAdrsWidth) == '0);
    assign dMemHitQ503H = (regionQ503H == dMemRegion) && ((wordOffQ503H >> dMemAdrsWidth) == '0);

    assign iMemWrEnB    = inFabricValidQ503H && iMemHitQ503H && (inFabric.opcode == opWrite);
    assign dMemWrEnB    = inFabricValidQ503H && dMemHitQ503H && (inFabric.opcode == opWrite);
    assign rdValidQ503H = inFabricValidQ503H && (inFabric.opcode == opRead);

    // ================================================
    // Q504H response stage
    // ================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            rdValidQ504H <= 1'b0;
            iMemHitQ504H <= 1'b0;
            dMemHitQ504H <= 1'b0;
        end else begin
            rdValidQ504H <= rdValidQ503H;
            iMemHitQ504H <= iMemHitQ503H;
            dMemHitQ504H <= dMemHitQ503H;
        end
    end

    // Reply goes back to the requestor's tile
    always_ff @(posedge Clock) begin
        rspAddrQ504H <= {inFabric.requestorId, inFabric.address[tileLsb-1:0]};
    end

    assign rspQ504H.address     = rspAddrQ504H;
    assign rspQ504H.data        = iMemHitQ504H ? iMemRdDataB :
                                  dMemHitQ504H ? dMemRdDataB :
                                                 '0;    // Unused region reads zero
    assign rspQ504H.opcode      = opReadRsp;
    assign rspQ504H.requestorId = localTileId;

    transFifo #(.depth(fifoDepth)) rspFifo (
        .Clock      (Clock),
        .reset      (reset),
        .push       (rdValidQ504H),
        .pushData   (rspQ504H),
        .pop        (rspPop),
        .popData    (rspHead),
        .empty      (rspEmpty),
        .full       (),
        .almostFull (inFabricStall)     // Leaves room for the one in flight
    );

endmodule

// ==== verilog/fabricOutArbiter.sv ====
// Round-robin arbiter between response and request queues, with
// the outgoing fabric mux

`timescale 1ns/100ps

module fabricOutArbiter (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 fabReady,
    input  logic                 rspEmpty,
    input  logic                 reqEmpty,
    input  tileMemPkg::tileTrans rspHead,
    input  tileMemPkg::tileTrans reqHead,
    output logic                 rspPop,
    output logic                 reqPop,
    output logic                 outFabricValid,
    output tileMemPkg::tileTrans outFabric
);
    import tileMemPkg::*;

    logic favorRsp;     // Points at the queue not granted last
    logic rspCand;
    logic reqCand;
    logic grantRsp;
    logic grantReq;

    // Nothing competes while the fabric is not ready
    assign rspCand = !rspEmpty && fabReady;
    assign reqCand = !reqEmpty && fabReady;

    assign grantRsp = rspCand && (favorRsp || !reqCand);
    assign grantReq = reqCand && !grantRsp;

    always_ff @(posedge Clock) begin
        if (reset) begin
            favorRsp <= 1'b1;               // Responses first out of reset
        end else if (grantRsp || grantReq) begin
            favorRsp <= grantReq;           // Flip towards the loser
        end
    end

    assign rspPop = grantRsp;               // Pop in the grant cycle
    assign reqPop = grantReq;

    assign outFabricValid = grantRsp || grantReq;
    assign outFabric      = grantRsp ? rspHead :
                            grantReq ? reqHead :
                                       '0;

endmodule

// ==== verilog/tileMemWrap.sv ====
// Tile memory wrapper top with instruction and data RAMs, core
// remote requester, fabric slave and outgoing arbiter

`timescale 1ns/100ps

module tileMemWrap #(
    parameter int iMemAdrsWidth = 10,
    parameter int dMemAdrsWidth = 10,
    parameter int fifoDepth     = 4
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  tileMemPkg::tileId    localTileId,
    // Core fetch
    input  tileMemPkg::word      pcQ100H,
    output tileMemPkg::word      instructionQ101H,
    // Core data
    input  tileMemPkg::word      dMemAddrQ103H,
    input  tileMemPkg::word      dMemWrDataQ103H,
    input  tileMemPkg::byteEn    dMemByteEnQ103H,
    input  logic                 dMemWrEnQ103H,
    input  logic                 dMemRdEnQ103H,
    output tileMemPkg::word      dMemRdRspQ104H,
    output logic                 coreStall,
    // Fabric in
    input  logic                 inFabricValidQ503H,
    input  tileMemPkg::tileTrans inFabric,
    output logic                 inFabricStall,
    // Fabric out
    input  logic                 fabReady,
    output logic                 outFabricValid,
    output tileMemPkg::tileTrans outFabric
);
    import tileMemPkg::*;

    logic     localWrEnQ103H;
    logic     iMemWrEnB;
    logic     dMemWrEnB;
    word      iMemRdDataB;
    word      dMemRdDataB;
    logic     rspPop;
    logic     reqPop;
    logic     rspEmpty;
    logic     reqEmpty;
    tileTrans rspHead;
    tileTrans reqHead;

    // ================================================
    // Memories
    // ================================================
    dualPortRam #(.adrsWidth(iMemAdrsWidth)) iMem (
        .Clock   (Clock),
        .addrA   (pcQ100H[iMemAdrsWidth+1:2]),  // Fetch, read only
        .wrDataA ('0),
        .wrEnA   (1'b0),
        .byteEnA ('0),
        .rdDataA (instructionQ101H),
        .addrB   (inFabric.address[iMemAdrsWidth+1:2]),
        .wrDataB (inFabric.data),
        .wrEnB   (iMemWrEnB),
        .byteEnB ('1),                          // Full-word fabric writes
        .rdDataB (iMemRdDataB)
    );

    dualPortRam #(.adrsWidth(dMemAdrsWidth)) dMem (
        .Clock   (Clock),
        .addrA   (dMemAddrQ103H[dMemAdrsWidth+1:2]),
        .wrDataA (dMemWrDataQ103H),
        .wrEnA   (localWrEnQ103H),
        .byteEnA (dMemByteEnQ103H),
        .rdDataA (dMemRdRspQ104H),
        .addrB   (inFabric.address[dMemAdrsWidth+1:2]),
        .wrDataB (inFabric.data),
        .wrEnB   (dMemWrEnB),
        .byteEnB ('1),
        .rdDataB (dMemRdDataB)
    );

    // ================================================
    // Fabric side
    // ================================================
    coreRemoteRequester #(.fifoDepth(fifoDepth)) requester (
        .Clock           (Clock),
        .reset           (reset),
        .localTileId     (localTileId),
        .dMemAddrQ103H   (dMemAddrQ103H),
        .dMemWrDataQ103H (dMemWrDataQ103H),
        .dMemWrEnQ103H   (dMemWrEnQ103H),
        .dMemRdEnQ103H   (dMemRdEnQ103H),
        .localWrEnQ103H  (localWrEnQ103H),
        .reqPop          (reqPop),
        .reqHead         (reqHead),
        .reqEmpty        (reqEmpty),
        .coreStall       (coreStall)
    );

    fabricSlave #(
        .iMemAdrsWidth (iMemAdrsWidth),
        .dMemAdrsWidth (dMemAdrsWidth),
        .fifoDepth     (fifoDepth)
    ) slave (
        .Clock              (Clock),
        .reset              (reset),
        .localTileId        (localTileId),
        .inFabricValidQ503H (inFabricValidQ503H),
        .inFabric           (inFabric),
        .iMemWrEnB          (iMemWrEnB),
        .dMemWrEnB          (dMemWrEnB),
        .iMemRdDataB        (iMemRdDataB),
        .dMemRdDataB        (dMemRdDataB),
        .rspPop             (rspPop),
        .rspHead            (rspHead),
        .rspEmpty           (rspEmpty),
        .inFabricStall      (inFabricStall)
    );

    fabricOutArbiter outArb (
        .Clock          (Clock),
        .reset          (reset),
        .fabReady       (fabReady),
        .rspEmpty       (rspEmpty),
        .reqEmpty       (reqEmpty),
        .rspHead        (rspHead),
        .reqHead        (reqHead),
        .rspPop         (rspPop),
        .reqPop         (reqPop),
        .outFabricValid (outFabricValid),
        .outFabric      (outFabric)
    );

endmodule

// ==== include/tileMemChecks.svh ====
// Compare tasks, reference-model storage and model helpers for
// the tile memory testbench

`ifndef TILE_MEM_CHECKS_SVH
`define TILE_MEM_CHECKS_SVH

// Model state
word      iMemModel [int];      // Keyed by word address
word      dMemModel [int];
tileTrans expRspQ [$];          // Expected responses, in order
tileTrans expReqQ [$];          // Expected core requests, in order
int       passCount  = 0;
int       errorCount = 0;

task automatic checkWord(input word expected, input word actual, input string msg);
    if (actual !== expected) begin
        errorCount++;
        $display("FAILED %0t %s: expected %h got %h", $time, msg, expected, actual);
    end else begin
        passCount++;
    end
endtask

task automatic checkTrans(input tileTrans expected, input tileTrans actual, input string msg);
    if (actual !== expected) begin
        errorCount++;
        $display("FAILED %0t %s: expected %h got %h", $time, msg, expected, actual);
    end else begin
        passCount++;
    end
endtask

// Byte-lane merge as done by a masked RAM write
function automatic word mergeBytes(input word oldWord, input word newWord, input byteEn be);
    word result;
    result = oldWord;
    for (int i = 0; i < 4; i++) begin
        if (be[i]) result[8*i +: 8] = newWord[8*i +: 8];
    end
    return result;
endfunction

`endif

// ==== verification/tileMemWrapTb.sv ====
// Testbench for the tile memory wrapper with a RAM and queue model,
// an outgoing-fabric scoreboard, a watchdog and the final report

`timescale 1ns/100ps

module tileMemWrapTb;
    import tileMemPkg::*;
    `include "tileMemChecks.svh"

    localparam int    iMemAdrsWidth = 10;
    localparam int    dMemAdrsWidth = 10;
    localparam int    fifoDepth     = 4;
    localparam tileId myTile        = 8'd5;
    localparam int    nOps          = 16;
    // Planned cycles per test: fetch, data, fabric read, remote, back-pressure, reset
    localparam int    planCycles    = 40 + 80 + 60 + 60 + 160 + 30;
    localparam int    timeoutCycles = 2 * planCycles + 200;

    logic       Clock = 1'b0;
    logic       reset;
    tileId      localTileId;
    word        pcQ100H;
    word        instructionQ101H;
    word        dMemAddrQ103H;
    word        dMemWrDataQ103H;
    byteEn      dMemByteEnQ103H;
    logic       dMemWrEnQ103H;
    logic       dMemRdEnQ103H;
    word        dMemRdRspQ104H;
    logic       coreStall;
    logic       inFabricValidQ503H;
    tileTrans   inFabric;
    logic       inFabricStall;
    logic       fabReady;
    logic       outFabricValid;
    tileTrans   outFabric;

    logic [9:0] iWritten [$];       // Word addresses with known contents
    logic [9:0] dWritten [$];
    logic       lastWasRsp;         // Source of the last grant seen
    int         cycleCount = 0;

    always #10 Clock = ~Clock;      // 20 ns period

    tileMemWrap #(
        .iMemAdrsWidth (iMemAdrsWidth),
        .dMemAdrsWidth (dMemAdrsWidth),
        .fifoDepth     (fifoDepth)
    ) DUT (
        .Clock              (Clock),
        .reset              (reset),
        .localTileId        (localTileId),
        .pcQ100H            (pcQ100H),
        .instructionQ101H   (instructionQ101H),
        .dMemAddrQ103H      (dMemAddrQ103H),
        .dMemWrDataQ103H    (dMemWrDataQ103H),
        .dMemByteEnQ103H    (dMemByteEnQ103H),
        .dMemWrEnQ103H      (dMemWrEnQ103H),
        .dMemRdEnQ103H      (dMemRdEnQ103H),
        .dMemRdRspQ104H     (dMemRdRspQ104H),
        .coreStall          (coreStall),
        .inFabricValidQ503H (inFabricValidQ503H),
        .inFabric           (inFabric),
        .inFabricStall      (inFabricStall),
        .fabReady           (fabReady),
        .outFabricValid     (outFabricValid),
        .outFabric          (outFabric)
    );

    // ================================================
    // Stimulus helpers
    // ================================================
    // Tile, region and word offset, 10-bit word addresses
    function automatic word regionAddr(input tileId tile, input logic [1:0] region,
                                       input logic [9:0] wa);
        return {tile, region, 10'b0, wa, 2'b00};
    endfunction

    function automatic tileId randomRemoteTile();
        tileId t;
        do t = tileId'($urandom); while (t == 8'd0 || t == myTile);
        return t;
    endfunction

    // Next falling edge, strobes drop back to idle
    task automatic step();
        @(negedge Clock);
        inFabricValidQ503H = 1'b0;
        dMemWrEnQ103H      = 1'b0;
        dMemRdEnQ103H      = 1'b0;
    endtask

    task automatic startFabricWrite(input logic [1:0] region, input logic [9:0] wa,
                                    input word data);
        inFabric.address     = regionAddr(myTile, region, wa);
        inFabric.data        = data;
        inFabric.opcode      = opWrite;
        inFabric.requestorId = tileId'($urandom);
        inFabricValidQ503H   = 1'b1;
        if (region == iMemRegion) iMemModel[wa] = data;
        else dMemModel[wa] = data;
    endtask

    // Read request plus the response it should produce
    task automatic startFabricRead(input logic [1:0] region, input logic [9:0] wa);
        tileTrans rsp;
        inFabric.address     = regionAddr(myTile, region, wa);
        inFabric.data        = $urandom;            // Ignored on a read
        inFabric.opcode      = opRead;
        inFabric.requestorId = tileId'($urandom);
        inFabricValidQ503H   = 1'b1;
        rsp.address     = {inFabric.requestorId, inFabric.address[23:0]};  // Back to sender
        rsp.opcode      = opReadRsp;
        rsp.requestorId = myTile;
        if (region == iMemRegion) rsp.data = iMemModel[wa];
        else if (region == dMemRegion) rsp.data = dMemModel[wa];
        else rsp.data = '0;                         // Unused region
        expRspQ.push_back(rsp);
    endtask

    task automatic startRandomRead();
        int unsigned pick;
        pick = $urandom % 3;
        if (pick == 0) startFabricRead(iMemRegion, iWritten[$urandom % iWritten.size()]);
        else if (pick == 1) startFabricRead(dMemRegion, dWritten[$urandom % dWritten.size()]);
        else startFabricRead(2'(2 + $urandom % 2), 10'($urandom));
    endtask

    // Core data access, local ones update the model, remote ones expect a request
    task automatic startCoreAccess(input word addr, input word data, input byteEn be,
                                   input logic wr);
        word        oldWord;
        logic [9:0] wa;
        tileTrans   req;
        wa              = addr[dMemAdrsWidth+1:2];
        dMemAddrQ103H   = addr;
        dMemWrDataQ103H = data;
        dMemByteEnQ103H = be;
        dMemWrEnQ103H   = wr;
        dMemRdEnQ103H   = !wr;
        if (addr[31:24] == myTile || addr[31:24] == 8'd0) begin
            if (wr) begin
                oldWord = dMemModel.exists(wa) ? dMemModel[wa] : '0;
                dMemModel[wa] = mergeBytes(oldWord, data, be);
            end
        end else begin
            req.address     = addr;
            req.data        = data;
            req.opcode      = wr ? opWrite : opRead;
            req.requestorId = myTile;
            expReqQ.push_back(req);
        end
    endtask

    task automatic startRemoteAccess();
        startCoreAccess({randomRemoteTile(), 24'($urandom)}, $urandom, byteEn'($urandom),
                        1'($urandom));
    endtask

    // Let everything expected leave the tile
    task automatic drain();
        fabReady = 1'b1;
        while (expRspQ.size() > 0 || expReqQ.size() > 0) step();
        repeat (3) step();                          // Catch late extras
    endtask

    task automatic reportTest(input int num, input string name, input int errBefore);
        $display("Test %0d %s finished, %0d errors", num, name, errorCount - errBefore);
    endtask

    // ================================================
    // Outgoing fabric scoreboard
    // ================================================
    always @(posedge Clock) begin
        tileTrans expTrans;
        logic     isRsp;
        if (reset) begin
            lastWasRsp = 1'b0;                      // Responses favoured after reset
        end else if (outFabricValid) begin
            isRsp = (outFabric.opcode == opReadRsp);
            if (!fabReady) begin
                errorCount++;
                $display("FAILED %0t outFabricValid high while fabReady low", $time);
            end
            if (!DUT.rspEmpty && !DUT.reqEmpty && isRsp == lastWasRsp) begin
                errorCount++;
                $display("FAILED %0t same source granted twice with both pending", $time);
            end
            lastWasRsp = isRsp;
            if (isRsp && expRspQ.size() == 0) begin
                errorCount++;
                $display("FAILED %0t unexpected response %h", $time, outFabric);
            end else if (!isRsp && expReqQ.size() == 0) begin
                errorCount++;
                $display("FAILED %0t unexpected request %h", $time, outFabric);
            end else if (isRsp) begin
                expTrans = expRspQ.pop_front();
                checkTrans(expTrans, outFabric, "read response");
            end else begin
                expTrans = expReqQ.pop_front();
                checkTrans(expTrans, outFabric, "remote request");
            end
        end
    end

    // Watchdog
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("Run timed out after %0d cycles before all tests finished", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    // ================================================
    // Test sequence
    // ================================================
    initial begin
        int unsigned seedDummy;
        int          errBefore;
        logic [9:0]  wa;
        tileId       tile;
        seedDummy          = $urandom(32'h57e2_62de);
        reset              = 1'b1;
        localTileId        = myTile;
        pcQ100H            = '0;
        dMemAddrQ103H      = '0;
        dMemWrDataQ103H    = '0;
        dMemByteEnQ103H    = '0;
        dMemWrEnQ103H      = 1'b0;
        dMemRdEnQ103H      = 1'b0;
        inFabricValidQ503H = 1'b0;
        inFabric           = '0;
        fabReady           = 1'b1;
        repeat (4) @(negedge Clock);
        reset = 1'b0;

        // Fabric fills the instruction RAM, fetch reads it back
        errBefore = errorCount;
        for (int i = 0; i < nOps; i++) begin
            wa = 10'($urandom);
            startFabricWrite(iMemRegion, wa, $urandom);
            iWritten.push_back(wa);
            step();
        end
        foreach (iWritten[i]) begin
            pcQ100H = {20'b0, iWritten[i], 2'b00};
            step();
            checkWord(iMemModel[iWritten[i]], instructionQ101H,
                      $sformatf("fetch word %0d", iWritten[i]));
        end
        reportTest(1, "instruction fetch", errBefore);

        // Local writes via tile 0 and 5, then byte-masked updates and fabric writes
        errBefore = errorCount;
        for (int i = 0; i < nOps; i++) begin
            wa   = 10'($urandom);
            tile = (i % 2) ? myTile : 8'd0;
            startCoreAccess(regionAddr(tile, 2'b00, wa), $urandom, 4'hf, 1'b1);
            dWritten.push_back(wa);
            step();
        end
        for (int i = 0; i < nOps; i++) begin
            wa   = dWritten[$urandom % dWritten.size()];
            tile = (i % 2) ? 8'd0 : myTile;
            startCoreAccess(regionAddr(tile, 2'b00, wa), $urandom, byteEn'($urandom), 1'b1);
            step();
        end
        for (int i = 0; i < nOps / 2; i++) begin
            wa = 10'($urandom);
            startFabricWrite(dMemRegion, wa, $urandom);
            dWritten.push_back(wa);
            step();
        end
        foreach (dWritten[i]) begin
            startCoreAccess(regionAddr(myTile, 2'b00, dWritten[i]), '0, '0, 1'b0);
            step();
            checkWord(dMemModel[dWritten[i]], dMemRdRspQ104H,
                      $sformatf("core read word %0d", dWritten[i]));
        end
        reportTest(2, "core data port", errBefore);

        // Fabric reads of all regions
        errBefore = errorCount;
        for (int i = 0; i < 24; i++) begin
            while (inFabricStall) step();
            startRandomRead();
            step();
        end
        drain();
        reportTest(3, "fabric reads", errBefore);

        // Remote core accesses mixed with local writes
        errBefore = errorCount;
        for (int i = 0; i < nOps; i++) begin
            while (coreStall) step();
            if ($urandom % 4 != 0) begin
                startRemoteAccess();
            end else begin
                wa = dWritten[$urandom % dWritten.size()];
                startCoreAccess(regionAddr(myTile, 2'b00, wa), $urandom, byteEn'($urandom), 1'b1);
            end
            step();
        end
        drain();
        reportTest(4, "remote requests", errBefore);

        // Both sources busy, fabReady random
        errBefore = errorCount;
        for (int i = 0; i < 100; i++) begin
            fabReady = 1'($urandom);
            if (!inFabricStall && ($urandom % 4 != 0)) startRandomRead();
            if (!coreStall && ($urandom % 4 != 0)) startRemoteAccess();
            step();
        end
        drain();
        reportTest(5, "back-pressure", errBefore);

        // Reset with both queues busy, then fill the request FIFO with the fabric stopped
        errBefore = errorCount;
        fabReady  = 1'b0;
        for (int i = 0; i < fifoDepth; i++) begin
            startRemoteAccess();
            if (!inFabricStall) startRandomRead();
            step();
        end
        // Request FIFO full, three responses queued and one in flight
        checkWord(32'd1, word'(coreStall), "coreStall before reset");
        checkWord(32'd1, word'(inFabricStall), "inFabricStall before reset");
        reset = 1'b1;
        expRspQ.delete();                           // Queued traffic is flushed
        expReqQ.delete();
        repeat (4) @(negedge Clock);
        reset = 1'b0;
        checkWord(32'd0, word'(outFabricValid), "outFabricValid after reset");
        checkWord(32'd0, word'(coreStall), "coreStall after reset");
        checkWord(32'd0, word'(inFabricStall), "inFabricStall after reset");
        fabReady = 1'b0;
        for (int i = 0; i < fifoDepth; i++) begin
            checkWord(32'd0, word'(coreStall), $sformatf("coreStall with %0d queued", i));
            startRemoteAccess();
            step();
        end
        checkWord(32'd1, word'(coreStall), "coreStall with request FIFO full");
        drain();
        reportTest(6, "reset and stall", errBefore);

        $display("Checks passed %0d, errors %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tileMemWrap.f ====
+incdir+include
verilog/tileMemPkg.sv
verilog/dualPortRam.sv
verilog/transFifo.sv
verilog/coreRemoteRequester.sv
verilog/fabricSlave.sv
verilog/fabricOutArbiter.sv
verilog/tileMemWrap.sv
verification/tileMemWrapTb.sv

// ==== Makefile ====
# Verilator build and run of the tile memory wrapper testbench

VERILATOR ?= verilator
TOP       ?= tileMemWrapTb
FILELIST  ?= tileMemWrap.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASSTEXT  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS PASSTEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASSTEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
